//--- design/avr_alu.sv
`timescale 1ns/1ps

module avr_alu
   import avr_pkg::*;
(
   gpr_if.alu      gpr,
   flag_if.alu     flg,
   input  alu_op_t alu_op,
   input  byte_t   imm,
   input  logic    use_imm,
   output byte_t   result
);

   byte_t d;
   byte_t r;
   logic  c_in;
   logic  is_add;
   logic  is_sub;
   logic  res_zero;

   assign d    = gpr.rd_data;
   assign r    = use_imm ? imm : gpr.rr_data;
   assign c_in = flg.sreg[FLAG_C];

   assign is_add = (alu_op == ALU_ADD) || (alu_op == ALU_ADC);
   assign is_sub = (alu_op == ALU_SUB) || (alu_op == ALU_SBC);

   // ****************************************
   // Result
   // ****************************************
   always_comb
   begin
      case (alu_op)
         ALU_ADD: result = d + r;
         ALU_ADC: result = d + r + {7'b0, c_in};
         ALU_SUB: result = d - r;
         ALU_SBC: result = d - r - {7'b0, c_in};
         ALU_AND: result = d & r;
         ALU_OR:  result = d | r;
         ALU_EOR: result = d ^ r;
         default: result = r;
      endcase
   end

   assign res_zero = (result == '0);

   // ****************************************
   // Flags, per the AVR equations
   // ****************************************
   always_comb
   begin
      // Logic ops leave V at zero
      flg.alu_h = 1'b0;
      flg.alu_v = 1'b0;
      flg.alu_c = 1'b0;
      if (is_add)
      begin
         flg.alu_h = (d[3] & r[3]) | (r[3] & ~result[3]) | (~result[3] & d[3]);
         flg.alu_v = (d[7] & r[7] & ~result[7]) | (~d[7] & ~r[7] & result[7]);
         flg.alu_c = (d[7] & r[7]) | (r[7] & ~result[7]) | (~result[7] & d[7]);
      end
      else if (is_sub)
      begin
         flg.alu_h = (~d[3] & r[3]) | (r[3] & result[3]) | (result[3] & ~d[3]);
         flg.alu_v = (d[7] & ~r[7] & ~result[7]) | (~d[7] & r[7] & result[7]);
         flg.alu_c = (~d[7] & r[7]) | (r[7] & result[7]) | (result[7] & ~d[7]);
      end
   end

   assign flg.alu_n = result[7];
   assign flg.alu_s = result[7] ^ flg.alu_v;

   // SBC chains Z across bytes of a multi-byte subtract
   assign flg.alu_z = (alu_op == ALU_SBC) ? (res_zero & flg.sreg[FLAG_Z]) : res_zero;

endmodule

//--- design/avr_core_top.sv
`timescale 1ns/1ps

module avr_core_top
   import avr_pkg::*;
(
   input  logic        cp2,
   input  logic        rst_n,
   input  logic [15:0] instr,
   input  logic        instr_valid,
   output logic        instr_ready,
   output logic        io_valid,
   output io_adr_t     io_adr,
   output byte_t       io_data,
   input  logic        io_ready
);

   logic    io_busy;
   logic    out_load;
   io_adr_t out_adr;
   alu_op_t alu_op;
   byte_t   imm;
   logic    use_imm;
   byte_t   alu_result;

   gpr_if  gpr_bus ();
   flag_if flag_bus ();

   // ****************************************
   // Decode and control
   // ****************************************
   avr_ctrl u_ctrl (
      .cp2         (cp2),
      .rst_n       (rst_n),
      .instr       (instr),
      .instr_valid (instr_valid),
      .instr_ready (instr_ready),
      .gpr         (gpr_bus.ctrl),
      .flg         (flag_bus.ctrl),
      .io_busy     (io_busy),
      .alu_result  (alu_result),
      .out_load    (out_load),
      .out_adr     (out_adr),
      .alu_op      (alu_op),
      .imm         (imm),
      .use_imm     (use_imm)
   );

   avr_reg_file u_reg_file (
      .cp2   (cp2),
      .rst_n (rst_n),
      .gpr   (gpr_bus.rf)
   );

   avr_alu u_alu (
      .gpr     (gpr_bus.alu),
      .flg     (flag_bus.alu),
      .alu_op  (alu_op),
      .imm     (imm),
      .use_imm (use_imm),
      .result  (alu_result)
   );

   avr_sreg u_sreg (
      .cp2   (cp2),
      .rst_n (rst_n),
      .flg   (flag_bus.status)
   );

   // OUT data is Rr passed through the ALU
   avr_io_out u_io_out (
      .cp2      (cp2),
      .rst_n    (rst_n),
      .load     (out_load),
      .adr      (out_adr),
      .data     (alu_result),
      .io_valid (io_valid),
      .io_adr   (io_adr),
      .io_data  (io_data),
      .io_ready (io_ready),
      .busy     (io_busy)
   );

endmodule

//--- design/avr_ctrl.sv
`timescale 1ns/1ps

module avr_ctrl
   import avr_pkg::*;
(
   input  logic    cp2,
   input  logic    rst_n,
   input  instr_u  instr,
   input  logic    instr_valid,
   output logic    instr_ready,
   gpr_if.ctrl     gpr,
   flag_if.ctrl    flg,
   input  logic    io_busy,
   input  byte_t   alu_result,
   output logic    out_load,
   output io_adr_t out_adr,
   output alu_op_t alu_op,
   output byte_t   imm,
   output logic    use_imm
);

   logic    accept;
   logic    op_add, op_adc, op_sub, op_sbc;
   logic    op_and, op_or, op_eor, op_mov;
   logic    op_ldi, op_subi, op_andi, op_ori;
   logic    op_in, op_out;
   logic    is_imm;
   logic    is_arith;
   logic    is_logic;
   io_adr_t io_adr;

   // Stall only while an I/O write waits for io_ready
   assign instr_ready = ~io_busy;
   assign accept      = instr_valid & instr_ready;

   // ****************************************
   // Decode through both views of the word
   // ****************************************
   assign op_add  = instr.r.opcode == OPC_ADD;
   assign op_adc  = instr.r.opcode == OPC_ADC;
   assign op_sub  = instr.r.opcode == OPC_SUB;
   assign op_sbc  = instr.r.opcode == OPC_SBC;
   assign op_and  = instr.r.opcode == OPC_AND;
   assign op_or   = instr.r.opcode == OPC_OR;
   assign op_eor  = instr.r.opcode == OPC_EOR;
   assign op_mov  = instr.r.opcode == OPC_MOV;
   assign op_in   = instr.r.opcode[5:1] == OPC_IN;
   assign op_out  = instr.r.opcode[5:1] == OPC_OUT;
   assign op_ldi  = instr.i.opcode == OPI_LDI;
   assign op_subi = instr.i.opcode == OPI_SUBI;
   assign op_andi = instr.i.opcode == OPI_ANDI;
   assign op_ori  = instr.i.opcode == OPI_ORI;

   assign is_imm   = op_ldi | op_subi | op_andi | op_ori;
   assign is_arith = op_add | op_adc | op_sub | op_sbc | op_subi;
   assign is_logic = op_and | op_or | op_eor | op_andi | op_ori;

   // A5 sits in the low opcode bit, A4 in the Rr high bit
   assign io_adr  = {instr.r.opcode[0], instr.r.rr_hi, instr.r.rr_lo};
   assign imm     = {instr.i.k_hi, instr.i.k_lo};
   assign use_imm = is_imm;

   // Immediate forms address r16..r31; OUT reads its source through Rr
   assign gpr.rd_adr = is_imm ? {1'b1, instr.i.rd_lo} : instr.r.rd;
   assign gpr.rr_adr = op_out ? instr.r.rd : {instr.r.rr_hi, instr.r.rr_lo};

   always_comb
   begin
      case (1'b1)
         op_add:          alu_op = ALU_ADD;
         op_adc:          alu_op = ALU_ADC;
         op_sub, op_subi: alu_op = ALU_SUB;
         op_sbc:          alu_op = ALU_SBC;
         op_and, op_andi: alu_op = ALU_AND;
         op_or, op_ori:   alu_op = ALU_OR;
         op_eor:          alu_op = ALU_EOR;
         default:         alu_op = ALU_PASS_R;
      endcase
   end

   // Write-back source
   always_comb
   begin
      if (op_ldi)
         gpr.wr_data = imm;
      else if (op_in)
         gpr.wr_data = (io_adr == SREG_ADR) ? flg.sreg : '0;
      else
         gpr.wr_data = alu_result;
   end

   assign gpr.wr_en = accept & (is_arith | is_logic | op_mov | op_ldi | op_in);

   // ****************************************
   // SREG update
   // ****************************************
   always_comb
   begin
      flg.new_flags         = '0;
      flg.new_flags[FLAG_H] = flg.alu_h;
      flg.new_flags[FLAG_S] = flg.alu_s;
      flg.new_flags[FLAG_V] = flg.alu_v;
      flg.new_flags[FLAG_N] = flg.alu_n;
      flg.new_flags[FLAG_Z] = flg.alu_z;
      flg.new_flags[FLAG_C] = flg.alu_c;

      flg.flag_we = '0;
      if (accept && (is_arith || is_logic))
      begin
         flg.flag_we[FLAG_S] = 1'b1;
         flg.flag_we[FLAG_V] = 1'b1;
         flg.flag_we[FLAG_N] = 1'b1;
         flg.flag_we[FLAG_Z] = 1'b1;
         // H and C only for add/subtract
         flg.flag_we[FLAG_H] = is_arith;
         flg.flag_we[FLAG_C] = is_arith;
      end
   end

   assign out_load = accept & op_out;
   assign out_adr  = io_adr;

   // SREG and the register under Rd keep their value over a cycle without a word
   a_write_needs_accept: assert property (@(posedge cp2) disable iff (!rst_n)
      !accept |=> $stable(flg.sreg)
                  && ((gpr.rd_adr != $past(gpr.rd_adr)) || $stable(gpr.rd_data)));

endmodule

//--- design/avr_ifs.sv
`timescale 1ns/1ps

// General purpose register file access
interface gpr_if
   import avr_pkg::*;
();

   reg_adr_t rd_adr;
   reg_adr_t rr_adr;
   byte_t    rd_data;
   byte_t    rr_data;
   byte_t    wr_data;
   logic     wr_en;

   modport ctrl (output rd_adr, rr_adr, wr_data, wr_en, input rd_data, rr_data);
   modport rf   (input rd_adr, rr_adr, wr_data, wr_en, output rd_data, rr_data);
   modport alu  (input rd_data, rr_data);

endinterface

// ALU flags and SREG update
interface flag_if
   import avr_pkg::*;
();

   sreg_t new_flags;
   sreg_t flag_we;
   sreg_t sreg;
   logic  alu_h;
   logic  alu_s;
   logic  alu_v;
   logic  alu_n;
   logic  alu_z;
   logic  alu_c;

   modport alu    (output alu_h, alu_s, alu_v, alu_n, alu_z, alu_c, input sreg);
   modport ctrl   (output new_flags, flag_we,
                   input alu_h, alu_s, alu_v, alu_n, alu_z, alu_c, sreg);
   modport status (input new_flags, flag_we, output sreg);

endinterface

//--- design/avr_io_out.sv
`timescale 1ns/1ps

module avr_io_out
   import avr_pkg::*;
(
   input  logic    cp2,
   input  logic    rst_n,
   input  logic    load,
   input  io_adr_t adr,
   input  byte_t   data,
   output logic    io_valid,
   output io_adr_t io_adr,
   output byte_t   io_data,
   input  logic    io_ready,
   output logic    busy
);

   // Valid flag, a new load wins over a completing handshake
   always_ff @(posedge cp2)
   begin
      if (!rst_n)
         io_valid <= 1'b0;
      else if (load)
         io_valid <= 1'b1;
      else if (io_ready)
         io_valid <= 1'b0;
   end

   // Payload
   always_ff @(posedge cp2)
   begin
      if (load)
      begin
         io_adr  <= adr;
         io_data <= data;
      end
   end

   assign busy = io_valid & ~io_ready;

   a_hold_until_ready: assert property (@(posedge cp2) disable iff (!rst_n)
      (io_valid && !io_ready) |=> (io_valid && $stable(io_adr) && $stable(io_data)));

endmodule

//--- design/avr_pkg.sv
package avr_pkg;

   typedef logic [7:0] byte_t;
   typedef logic [4:0] reg_adr_t;
   typedef logic [5:0] io_adr_t;
   typedef logic [7:0] sreg_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_ADC,
      ALU_SUB,
      ALU_SBC,
      ALU_AND,
      ALU_OR,
      ALU_EOR,
      ALU_PASS_R
   } alu_op_t;

   // Two-register format, also used by IN/OUT
   typedef struct packed {
      logic [5:0] opcode;
      logic       rr_hi;
      reg_adr_t   rd;
      logic [3:0] rr_lo;
   } instr_reg_t;

   // Immediate format, Rd limited to r16..r31
   typedef struct packed {
      logic [3:0] opcode;
      logic [3:0] k_hi;
      logic [3:0] rd_lo;
      logic [3:0] k_lo;
   } instr_imm_t;

   typedef union packed {
      instr_reg_t r;
      instr_imm_t i;
   } instr_u;

   // ****************************************
   // Opcode patterns
   // ****************************************
   localparam logic [5:0] OPC_ADD = 6'b000011;
   localparam logic [5:0] OPC_ADC = 6'b000111;
   localparam logic [5:0] OPC_SUB = 6'b000110;
   localparam logic [5:0] OPC_SBC = 6'b000010;
   localparam logic [5:0] OPC_AND = 6'b001000;
   localparam logic [5:0] OPC_EOR = 6'b001001;
   localparam logic [5:0] OPC_OR  = 6'b001010;
   localparam logic [5:0] OPC_MOV = 6'b001011;

   // Upper five bits only, the sixth is address bit 5
   localparam logic [4:0] OPC_IN  = 5'b10110;
   localparam logic [4:0] OPC_OUT = 5'b10111;

   localparam logic [3:0] OPI_SUBI = 4'b0101;
   localparam logic [3:0] OPI_ORI  = 4'b0110;
   localparam logic [3:0] OPI_ANDI = 4'b0111;
   localparam logic [3:0] OPI_LDI  = 4'b1110;

   localparam io_adr_t SREG_ADR = 6'h3F;

   // SREG bit positions
   localparam int FLAG_C = 0;
   localparam int FLAG_Z = 1;
   localparam int FLAG_N = 2;
   localparam int FLAG_V = 3;
   localparam int FLAG_S = 4;
   localparam int FLAG_H = 5;
   localparam int FLAG_T = 6;
   localparam int FLAG_I = 7;

endpackage

//--- design/avr_reg_file.sv
`timescale 1ns/1ps

module avr_reg_file
   import avr_pkg::*;
(
   input logic cp2,
   input logic rst_n,
   gpr_if.rf   gpr
);

   byte_t regs [32];

   // ****************************************
   // r0..r31, single write port on Rd
   // ****************************************
   always_ff @(posedge cp2)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < 32; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (gpr.wr_en)
      begin
         regs[gpr.rd_adr] <= gpr.wr_data;
      end
   end

   // Asynchronous read ports
   assign gpr.rd_data = regs[gpr.rd_adr];
   assign gpr.rr_data = regs[gpr.rr_adr];

endmodule

//--- design/avr_sreg.sv
`timescale 1ns/1ps

module avr_sreg
   import avr_pkg::*;
(
   input logic    cp2,
   input logic    rst_n,
   flag_if.status flg
);

   // ****************************************
   // Status register with bitwise write enables
   // ****************************************
   always_ff @(posedge cp2)
   begin
      if (!rst_n)
      begin
         flg.sreg <= '0;
      end
      else
      begin
         flg.sreg <= (flg.sreg & ~flg.flag_we) | (flg.new_flags & flg.flag_we);
      end
   end

   // I and T have no writer in this core
   a_i_t_stay_low: assert property (@(posedge cp2) disable iff (!rst_n)
      !flg.sreg[FLAG_I] && !flg.sreg[FLAG_T]);

endmodule

//--- run.sh
#!/bin/sh
# Build and run the AVR core testbench with Verilator, from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f sim.f --top-module tb_avr_core -Mdir obj_dir -o tb_avr_core

status=0
./obj_dir/tb_avr_core > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TB FAILED" sim.log; then
   echo "Simulation reported failure"
   exit 1
fi

if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

//--- sim.f
design/avr_pkg.sv
design/avr_ifs.sv
design/avr_reg_file.sv
design/avr_alu.sv
design/avr_sreg.sv
design/avr_io_out.sv
design/avr_ctrl.sv
design/avr_core_top.sv
test/tb_avr_core.sv

//--- test/avr_golden.txt
// Entries: 1_wwww sends instruction word wwww, e_aa_dd expects an I/O write
// of data dd to address aa, f_0000 ends the list

// After reset SREG and registers read zero
1_b74f                    // IN   r20, 0x3F
1_b941  e_01_00           // OUT  0x01, r20
1_b852  e_02_00           // OUT  0x02, r5

// LDI then OUT
1_ea05                    // LDI  r16, 0xA5
1_b903  e_03_a5           // OUT  0x03, r16

// ADD with carry and half carry
1_e31c  1_ec28            // LDI  r17, 0x3C and LDI r18, 0xC8
1_0f12                    // ADD  r17, r18
1_b74f  1_b944  e_04_21   // IN   r20, SREG and OUT 0x04, r20
1_b915  e_05_04           // OUT  0x05, r17

// ADC takes the carry in
1_1f12                    // ADC  r17, r18
1_b916  e_06_cd
1_b74f  1_b947  e_07_14

// SUB with signed overflow
1_e830  1_e051            // LDI  r19, 0x80 and LDI r21, 0x01
1_1b35                    // SUB  r19, r21
1_b938  e_08_7f
1_b74f  1_b949  e_09_38

// Words outside the kept set: BRNE, RJMP, CP, ADIW
1_f7f1  1_cfff  1_1523  1_9601
1_b74f  1_b94a  e_0a_38

// SBC of zero keeps Z
1_1b66                    // SUB  r22, r22
1_0b77                    // SBC  r23, r23
1_b74f  1_b94b  e_0b_02

// Logic operations clear V
1_e830  1_1b35            // r19 back to 0x7F with V set
1_2331                    // AND  r19, r17
1_b74f  1_b94c  e_0c_20
1_b93d  e_0d_4d           // OUT  0x0D, r19
1_2b32                    // OR   r19, r18
1_2731                    // EOR  r19, r17
1_b74f  1_b94e  e_0e_22

// MOV and LDI leave the flags alone
1_2e20  1_ef9f            // MOV  r2, r16 and LDI r25, 0xFF
1_b82f  e_0f_a5           // OUT  0x0F, r2
1_b74f  1_bb40  e_10_22

// Immediates reach r16 to r31 only
1_5205  1_701f  1_6003    // SUBI r16, 0x25, ANDI r17, 0x0F, ORI r16, 0x03
1_bb01  e_11_83           // OUT  0x11, r16
1_bb12  e_12_0d           // OUT  0x12, r17
1_ba03  e_13_00           // OUT  0x13, r0
1_ba14  e_14_00           // OUT  0x14, r1
1_b74f  1_bb45  e_15_14

// IN from an address other than SREG
1_b141  1_bb46  e_16_00
f_0000

//--- test/tb_avr_core.sv
`timescale 1ns/1ps

module tb_avr_core
   import avr_pkg::*;
();

   localparam int         GOLDEN_DEPTH = 128;
   localparam logic [3:0] TAG_INSTR    = 4'h1;
   localparam logic [3:0] TAG_EXPECT   = 4'he;
   localparam logic [3:0] TAG_END      = 4'hf;

   logic        cp2 = 1'b0;
   logic        rst_n;
   logic [15:0] instr;
   logic        instr_valid;
   logic        instr_ready;
   logic        io_valid;
   io_adr_t     io_adr;
   byte_t       io_data;
   logic        io_ready = 1'b0;

   logic [19:0] golden [GOLDEN_DEPTH];
   logic [15:0] instr_q [$];
   io_adr_t     exp_adr_q [$];
   byte_t       exp_data_q [$];
   int          n_records;
   int          cycle_limit = 0;
   int          cycles = 0;
   int          value_errors = 0;
   int          other_errors = 0;
   int          setup_errors = 0;
   int          n_writes = 0;
   logic [31:0] rand_state = 32'd50;
   logic        out_accepted = 1'b0;
   logic        held_prev = 1'b0;
   io_adr_t     held_adr;
   byte_t       held_data;

   avr_core_top u_dut (
      .cp2         (cp2),
      .rst_n       (rst_n),
      .instr       (instr),
      .instr_valid (instr_valid),
      .instr_ready (instr_ready),
      .io_valid    (io_valid),
      .io_adr      (io_adr),
      .io_data     (io_data),
      .io_ready    (io_ready)
   );

   always #50 cp2 = ~cp2;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x ^ (x << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   task automatic check_adr(input io_adr_t got, input io_adr_t exp);
      if (got !== exp)
      begin
         $display("ERR io_adr got 0x%h expected 0x%h at write %0d", got, exp, n_writes);
         value_errors++;
      end
   endtask

   task automatic check_data(input byte_t got, input byte_t exp);
      if (got !== exp)
      begin
         $display("ERR io_data got 0x%h expected 0x%h at write %0d", got, exp, n_writes);
         value_errors++;
      end
   endtask

   // Split the golden entries into words to send and writes to expect
   task automatic read_golden();
      int         idx;
      logic       done;
      logic [3:0] tag;
      idx  = 0;
      done = 1'b0;
      $readmemh("test/avr_golden.txt", golden);
      while (!done)
      begin
         if (idx == GOLDEN_DEPTH)
         begin
            $display("Golden file has no end marker");
            setup_errors++;
            done = 1'b1;
         end
         else
         begin
            tag = golden[idx][19:16];
            case (tag)
               TAG_INSTR:
                  instr_q.push_back(golden[idx][15:0]);
               TAG_EXPECT:
               begin
                  exp_adr_q.push_back(golden[idx][13:8]);
                  exp_data_q.push_back(golden[idx][7:0]);
               end
               TAG_END:
                  done = 1'b1;
               default:
               begin
                  $display("Golden file entry %0d has an unknown tag", idx);
                  setup_errors++;
                  done = 1'b1;
               end
            endcase
            idx++;
         end
      end
      n_records = instr_q.size() + exp_adr_q.size();
      if (instr_q.size() == 0)
      begin
         $display("Golden file holds no instruction words");
         setup_errors++;
      end
   endtask

   // Random back-pressure, roughly three cycles in four ready
   always @(posedge cp2)
   begin
      #5;
      rand_state = xorshift32(rand_state);
      io_ready   = (rand_state[1:0] != 2'b00);
   end

   // ****************************************
   // I/O write monitor, sampled mid-cycle
   // ****************************************
   always @(negedge cp2)
   begin
      if (rst_n)
      begin
         if (out_accepted && io_valid !== 1'b1)
         begin
            $display("io_valid did not rise one cycle after an accepted OUT");
            other_errors++;
         end
         // A write waiting for io_ready must not move
         if (held_prev)
         begin
            if (io_valid !== 1'b1)
            begin
               $display("io_valid dropped before its handshake");
               other_errors++;
            end
            else
            begin
               check_adr(io_adr, held_adr);
               check_data(io_data, held_data);
            end
         end
         if (io_valid === 1'b1 && io_ready === 1'b1)
         begin
            if (n_writes >= exp_adr_q.size())
            begin
               $display("Unexpected extra I/O write to address 0x%h", io_adr);
               other_errors++;
            end
            else
            begin
               check_adr(io_adr, exp_adr_q[n_writes]);
               check_data(io_data, exp_data_q[n_writes]);
            end
            n_writes++;
         end
         held_prev    = (io_valid === 1'b1) && (io_ready !== 1'b1);
         held_adr     = io_adr;
         held_data    = io_data;
         out_accepted = instr_valid && instr_ready && (instr[15:11] == 5'b10111);
      end
   end

   always @(posedge cp2)
   begin
      cycles = cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit)
      begin
         $display("Timeout after %0d cycles, %0d I/O writes still missing",
                  cycles, exp_adr_q.size() - n_writes);
         $display("TB FAILED");
         $finish;
      end
   end

   // ****************************************
   // Reset, stimulus and final report
   // ****************************************
   initial
   begin
      rst_n       = 1'b0;
      instr       = '0;
      instr_valid = 1'b0;
      read_golden();
      cycle_limit = 10 * n_records + 50;

      repeat (3) @(posedge cp2);
      #5;
      rst_n = 1'b1;
      @(negedge cp2);
      if (io_valid !== 1'b0 || instr_ready !== 1'b1)
      begin
         $display("After reset io_valid is %b and instr_ready is %b", io_valid, instr_ready);
         setup_errors++;
      end
      @(posedge cp2);
      #5;

      // Hold each word until the core takes it
      foreach (instr_q[k])
      begin
         instr       = instr_q[k];
         instr_valid = 1'b1;
         @(negedge cp2);
         while (instr_ready !== 1'b1)
            @(negedge cp2);
         @(posedge cp2);
         #5;
      end
      instr_valid = 1'b0;
      instr       = '0;

      while (n_writes < exp_adr_q.size())
         @(posedge cp2);
      repeat (4) @(posedge cp2);

      $display("Writes %0d of %0d, value errors %0d, protocol errors %0d, setup errors %0d",
               n_writes, exp_adr_q.size(), value_errors, other_errors, setup_errors);
      if (value_errors == 0 && other_errors == 0 && setup_errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule
